//--- logic/platform_config.svh
/* Platform configuration: data bus address map, bus widths and timer width */

`ifndef PLATFORM_CONFIG_SVH
`define PLATFORM_CONFIG_SVH

// Bus widths
`define PLAT_ADDR_W 32
`define PLAT_DATA_W 32

// Main memory region
`define MEM_BASE    32'h0000_0000
`define MEM_LAST    32'h000F_FFFF

// IO windows, one per register block
`define GPIO_BASE   32'h0010_0000
`define TIMER_BASE  32'h0010_0010
`define IO_WINDOW   32'd16

// mtime and mtimecmp
`define TIMER_W     64

`endif

//--- logic/bus_pkg.sv
/* Data bus types: request and response payloads, opcodes, responses, targets */

`default_nettype none

`include "platform_config.svh"

package bus_pkg;

    typedef logic [`PLAT_ADDR_W-1:0]   addr_t;
    typedef logic [`PLAT_DATA_W-1:0]   data_t;
    typedef logic [`PLAT_DATA_W/8-1:0] strb_t;

    typedef enum logic {OP_READ, OP_WRITE} op_e;

    // Same encoding as the AXI4-lite xRESP field
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2,
        RESP_DECERR = 2'd3
    } resp_e;

    typedef enum logic [1:0] {TGT_MEM, TGT_GPIO, TGT_TIMER, TGT_NONE} target_e;

    typedef struct packed {
        op_e   op;
        addr_t addr;
        data_t wdata;
        strb_t strb;
    } bus_req_t;

    typedef struct packed {
        data_t rdata;
        resp_e resp;
    } bus_rsp_t;

endpackage

`default_nettype wire

//--- logic/io_pkg.sv
/* Register bank link types and the register maps of GPIO and timer */

`default_nettype none

package io_pkg;

    import bus_pkg::*;

    typedef struct packed {
        op_e        op;
        logic [3:0] offset;
        data_t      wdata;
        strb_t      strb;
    } io_req_t;

    typedef struct packed {
        data_t rdata;
        resp_e resp;
    } io_rsp_t;

    typedef enum logic [3:0] {
        GPIO_OUT = 4'h0,
        GPIO_IN  = 4'h4
    } gpio_reg_e;

    typedef enum logic [3:0] {
        MTIME_LO    = 4'h0,
        MTIME_HI    = 4'h4,
        MTIMECMP_LO = 4'h8,
        MTIMECMP_HI = 4'hC
    } timer_reg_e;

    // Byte lane merge shared by all register banks
    function automatic data_t apply_strobes(input data_t old_val, input data_t new_val,
                                            input strb_t strb);
        data_t merged;
        merged = old_val;
        for (int i = 0; i < $bits(strb_t); i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return merged;
    endfunction

endpackage

`default_nettype wire

//--- logic/request_slice.sv
/* Request slice: one registered stage on the incoming request channel */

`timescale 1ns/10ps
`default_nettype none

module request_slice (
    input  logic              aclk,
    input  logic              rst,
    input  logic              req_valid,
    output logic              req_ready,
    input  bus_pkg::bus_req_t req,
    output logic              stage_valid,
    input  logic              stage_ready,
    output bus_pkg::bus_req_t stage_req
);

    // Free when empty or when the entry leaves this cycle
    assign req_ready = !stage_valid || stage_ready;

    always_ff @(posedge aclk) begin
        if (rst) begin
            stage_valid <= 1'b0;
        end else if (req_ready) begin
            stage_valid <= req_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (req_valid && req_ready) begin
            stage_req <= req;
        end
    end

endmodule

`default_nettype wire

//--- logic/address_decoder.sv
/* Address decoder that routes each request to memory, GPIO or timer and
   returns one response at a time, with decode errors for unmapped space */

`timescale 1ns/10ps
`default_nettype none

`include "platform_config.svh"

module address_decoder (
    input  logic              aclk,
    input  logic              rst,
    input  logic              stage_valid,
    output logic              stage_ready,
    input  bus_pkg::bus_req_t stage_req,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output bus_pkg::bus_rsp_t rsp,
    output logic              mem_req_valid,
    input  logic              mem_req_ready,
    output bus_pkg::bus_req_t mem_req,
    input  logic              mem_rsp_valid,
    output logic              mem_rsp_ready,
    input  bus_pkg::bus_rsp_t mem_rsp,
    output logic              gpio_sel,
    output logic              timer_sel,
    output io_pkg::io_req_t   io_req,
    input  logic              gpio_ack,
    input  io_pkg::io_rsp_t   gpio_rsp,
    input  logic              timer_ack,
    input  io_pkg::io_rsp_t   timer_rsp
);

    import bus_pkg::*;
    import io_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_MEM_REQ, ST_WAIT, ST_RESP} state_e;

    state_e   state;
    target_e  tgt;
    target_e  tgt_q;
    addr_t    mem_off;
    addr_t    gpio_off;
    addr_t    timer_off;
    logic     accept;
    logic     rsp_done;
    bus_rsp_t rsp_next;

    //////////////////////////////
    // Address map
    //////////////////////////////

    assign mem_off   = stage_req.addr - `MEM_BASE;
    assign gpio_off  = stage_req.addr - `GPIO_BASE;
    assign timer_off = stage_req.addr - `TIMER_BASE;

    always_comb begin
        if (mem_off <= (`MEM_LAST - `MEM_BASE)) begin
            tgt = TGT_MEM;
        end else if (gpio_off < `IO_WINDOW) begin
            tgt = TGT_GPIO;
        end else if (timer_off < `IO_WINDOW) begin
            tgt = TGT_TIMER;
        end else begin
            tgt = TGT_NONE;
        end
    end

    assign stage_ready = (state == ST_IDLE);
    assign accept      = stage_valid && stage_ready;

    // Register banks are strobed in the accept cycle
    assign gpio_sel  = accept && (tgt == TGT_GPIO);
    assign timer_sel = accept && (tgt == TGT_TIMER);

    // IO windows are aligned to their size
    assign io_req.op     = stage_req.op;
    assign io_req.offset = stage_req.addr[3:0];
    assign io_req.wdata  = stage_req.wdata;
    assign io_req.strb   = stage_req.strb;

    //////////////////////////////
    // Completion of the outstanding request
    //////////////////////////////

    always_comb begin
        case (tgt_q)
            TGT_MEM: begin
                rsp_done = mem_rsp_valid;
                rsp_next = mem_rsp;
            end
            TGT_GPIO: begin
                rsp_done = gpio_ack;
                rsp_next = '{rdata: gpio_rsp.rdata, resp: gpio_rsp.resp};
            end
            TGT_TIMER: begin
                rsp_done = timer_ack;
                rsp_next = '{rdata: timer_rsp.rdata, resp: timer_rsp.resp};
            end
            default: begin
                rsp_done = 1'b1;
                rsp_next = '{rdata: '0, resp: RESP_DECERR};
            end
        endcase
    end

    assign mem_req_valid = (state == ST_MEM_REQ);
    assign mem_rsp_ready = (state == ST_WAIT) && (tgt_q == TGT_MEM);
    assign rsp_valid     = (state == ST_RESP);

    always_ff @(posedge aclk) begin
        if (rst) begin
            state <= ST_IDLE;
            tgt_q <= TGT_NONE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        tgt_q <= tgt;
                        state <= (tgt == TGT_MEM) ? ST_MEM_REQ : ST_WAIT;
                    end
                end
                ST_MEM_REQ: begin
                    if (mem_req_ready) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (rsp_done) begin
                        state <= ST_RESP;
                    end
                end
                default: begin
                    if (rsp_ready) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Payloads held for the whole handshake
    always_ff @(posedge aclk) begin
        if (accept) begin
            mem_req <= stage_req;
        end
        if (state == ST_WAIT && rsp_done) begin
            rsp <= rsp_next;
        end
    end

endmodule

`default_nettype wire

//--- logic/gpio_bank.sv
/* GPIO bank: byte-writable output register and synchronized input port */

`timescale 1ns/10ps
`default_nettype none

module gpio_bank (
    input  logic            aclk,
    input  logic            rst,
    input  logic            gpio_sel,
    input  io_pkg::io_req_t io_req,
    output logic            gpio_ack,
    output io_pkg::io_rsp_t gpio_rsp,
    input  bus_pkg::data_t  gpio_in,
    output bus_pkg::data_t  gpio_out
);

    import bus_pkg::*;
    import io_pkg::*;

    data_t gpio_meta;
    data_t gpio_sync;

    // Two-flop synchronizer on the pins
    always_ff @(posedge aclk) begin
        gpio_meta <= gpio_in;
        gpio_sync <= gpio_meta;
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            gpio_out <= '0;
            gpio_ack <= 1'b0;
        end else begin
            gpio_ack <= gpio_sel;
            if (gpio_sel && io_req.op == OP_WRITE && io_req.offset == GPIO_OUT) begin
                gpio_out <= apply_strobes(gpio_out, io_req.wdata, io_req.strb);
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (gpio_sel) begin
            case (io_req.offset)
                GPIO_OUT: gpio_rsp <= '{rdata: gpio_out, resp: RESP_OKAY};
                // Writes here are dropped
                GPIO_IN:  gpio_rsp <= '{rdata: gpio_sync, resp: RESP_OKAY};
                default:  gpio_rsp <= '{rdata: '0, resp: RESP_SLVERR};
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/machine_timer.sv
/* Machine timer: mtime counts rtc rising edges, timer_irq is raised
   while mtime has reached mtimecmp */

`timescale 1ns/10ps
`default_nettype none

`include "platform_config.svh"

module machine_timer (
    input  logic            aclk,
    input  logic            rst,
    input  logic            rtc,
    input  logic            timer_sel,
    input  io_pkg::io_req_t io_req,
    output logic            timer_ack,
    output io_pkg::io_rsp_t timer_rsp,
    output logic            timer_irq
);

    import bus_pkg::*;
    import io_pkg::*;

    logic [2:0]          rtc_sync;
    logic                rtc_tick;
    logic [`TIMER_W-1:0] mtime;
    logic [`TIMER_W-1:0] mtimecmp;
    logic                wr;

    // Two sync stages, third stage for the edge
    always_ff @(posedge aclk) begin
        if (rst) begin
            rtc_sync <= '0;
        end else begin
            rtc_sync <= {rtc_sync[1:0], rtc};
        end
    end

    assign rtc_tick = rtc_sync[1] && !rtc_sync[2];
    assign wr       = timer_sel && (io_req.op == OP_WRITE);

    //////////////////////////////
    // Counter and compare
    //////////////////////////////

    always_ff @(posedge aclk) begin
        if (rst) begin
            mtime <= '0;
        end else if (wr && io_req.offset == MTIME_LO) begin
            mtime[`PLAT_DATA_W-1:0] <= apply_strobes(mtime[`PLAT_DATA_W-1:0],
                                                     io_req.wdata, io_req.strb);
        end else if (wr && io_req.offset == MTIME_HI) begin
            mtime[`TIMER_W-1:`PLAT_DATA_W] <= apply_strobes(mtime[`TIMER_W-1:`PLAT_DATA_W],
                                                            io_req.wdata, io_req.strb);
        end else if (rtc_tick) begin
            mtime <= mtime + 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            mtimecmp <= '1;
        end else if (wr && io_req.offset == MTIMECMP_LO) begin
            mtimecmp[`PLAT_DATA_W-1:0] <= apply_strobes(mtimecmp[`PLAT_DATA_W-1:0],
                                                        io_req.wdata, io_req.strb);
        end else if (wr && io_req.offset == MTIMECMP_HI) begin
            mtimecmp[`TIMER_W-1:`PLAT_DATA_W] <= apply_strobes(
                mtimecmp[`TIMER_W-1:`PLAT_DATA_W], io_req.wdata, io_req.strb);
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            timer_irq <= 1'b0;
            timer_ack <= 1'b0;
        end else begin
            timer_irq <= (mtime >= mtimecmp);
            timer_ack <= timer_sel;
        end
    end

    // Read data is the value before any write in the same access
    always_ff @(posedge aclk) begin
        if (timer_sel) begin
            case (io_req.offset)
                MTIME_LO:    timer_rsp <= '{rdata: mtime[`PLAT_DATA_W-1:0], resp: RESP_OKAY};
                MTIME_HI:    timer_rsp <= '{rdata: mtime[`TIMER_W-1:`PLAT_DATA_W],
                                            resp: RESP_OKAY};
                MTIMECMP_LO: timer_rsp <= '{rdata: mtimecmp[`PLAT_DATA_W-1:0],
                                            resp: RESP_OKAY};
                MTIMECMP_HI: timer_rsp <= '{rdata: mtimecmp[`TIMER_W-1:`PLAT_DATA_W],
                                            resp: RESP_OKAY};
                default:     timer_rsp <= '{rdata: '0, resp: RESP_SLVERR};
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/platform_top.sv
/* Platform top: request slice, address decoder, GPIO bank and machine timer */

`timescale 1ns/10ps
`default_nettype none

module platform_top (
    input  logic              aclk,
    input  logic              rst,
    input  logic              rtc,
    input  bus_pkg::data_t    gpio_in,
    output bus_pkg::data_t    gpio_out,
    output logic              timer_irq,
    // Requester channels
    input  logic              req_valid,
    output logic              req_ready,
    input  bus_pkg::bus_req_t req,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output bus_pkg::bus_rsp_t rsp,
    // Main memory channels
    output logic              mem_req_valid,
    input  logic              mem_req_ready,
    output bus_pkg::bus_req_t mem_req,
    input  logic              mem_rsp_valid,
    output logic              mem_rsp_ready,
    input  bus_pkg::bus_rsp_t mem_rsp
);

    import bus_pkg::*;
    import io_pkg::*;

    logic     stage_valid;
    logic     stage_ready;
    bus_req_t stage_req;
    logic     gpio_sel;
    logic     timer_sel;
    io_req_t  io_req;
    logic     gpio_ack;
    io_rsp_t  gpio_rsp;
    logic     timer_ack;
    io_rsp_t  timer_rsp;

    request_slice slice (
        .aclk        (aclk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req         (req),
        .stage_valid (stage_valid),
        .stage_ready (stage_ready),
        .stage_req   (stage_req)
    );

    address_decoder decoder (
        .aclk          (aclk),
        .rst           (rst),
        .stage_valid   (stage_valid),
        .stage_ready   (stage_ready),
        .stage_req     (stage_req),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .rsp           (rsp),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_ready (mem_rsp_ready),
        .mem_rsp       (mem_rsp),
        .gpio_sel      (gpio_sel),
        .timer_sel     (timer_sel),
        .io_req        (io_req),
        .gpio_ack      (gpio_ack),
        .gpio_rsp      (gpio_rsp),
        .timer_ack     (timer_ack),
        .timer_rsp     (timer_rsp)
    );

    gpio_bank gpio (
        .aclk     (aclk),
        .rst      (rst),
        .gpio_sel (gpio_sel),
        .io_req   (io_req),
        .gpio_ack (gpio_ack),
        .gpio_rsp (gpio_rsp),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out)
    );

    machine_timer timer (
        .aclk      (aclk),
        .rst       (rst),
        .rtc       (rtc),
        .timer_sel (timer_sel),
        .io_req    (io_req),
        .timer_ack (timer_ack),
        .timer_rsp (timer_rsp),
        .timer_irq (timer_irq)
    );

endmodule

`default_nettype wire

//--- dv/platform_properties.sv
/* Platform properties: handshake stability, reset state of the
   response channel and timer interrupt against the compare value */

`timescale 1ns/10ps
`default_nettype none

`include "platform_config.svh"

module platform_properties (
    input logic                aclk,
    input logic                rst,
    input logic                req_valid,
    input logic                req_ready,
    input bus_pkg::bus_req_t   req,
    input logic                rsp_valid,
    input logic                rsp_ready,
    input bus_pkg::bus_rsp_t   rsp,
    input logic                mem_req_valid,
    input logic                mem_req_ready,
    input bus_pkg::bus_req_t   mem_req,
    input logic                timer_irq,
    input logic [`TIMER_W-1:0] mtime,
    input logic [`TIMER_W-1:0] mtimecmp
);

    int unsigned fail_count = 0;

    //////////////////////////////
    // Back-pressure
    //////////////////////////////

    req_hold: assert property (@(posedge aclk) disable iff (rst)
        req_valid && !req_ready |=> req_valid && $stable(req))
    else begin
        $error("Request dropped or changed while stalled");
        fail_count++;
    end

    rsp_hold: assert property (@(posedge aclk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else begin
        $error("Response dropped or changed while stalled");
        fail_count++;
    end

    mem_req_hold: assert property (@(posedge aclk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
    else begin
        $error("Memory request dropped or changed while stalled");
        fail_count++;
    end

    //////////////////////////////
    // Reset and timer
    //////////////////////////////

    rsp_after_reset: assert property (@(posedge aclk) $fell(rst) |-> !rsp_valid)
    else begin
        $error("Response valid in the first cycle after reset");
        fail_count++;
    end

    // irq is registered, so it follows the compare one cycle later
    irq_idle: assert property (@(posedge aclk) disable iff (rst)
        mtimecmp == '1 && mtime != '1 |=> !timer_irq)
    else begin
        $error("Timer interrupt raised with mtimecmp at its reset value");
        fail_count++;
    end

endmodule

bind platform_top platform_properties props (
    .aclk          (aclk),
    .rst           (rst),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .req           (req),
    .rsp_valid     (rsp_valid),
    .rsp_ready     (rsp_ready),
    .rsp           (rsp),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_req       (mem_req),
    .timer_irq     (timer_irq),
    .mtime         (timer.mtime),
    .mtimecmp      (timer.mtimecmp)
);

`default_nettype wire

//--- dv/platform_tb.sv
/* Platform testbench with a trace-driven requester, a main memory model,
   response checks and a watchdog */

`timescale 1ns/10ps
`default_nettype none

module platform_tb;

    import bus_pkg::*;

    localparam int SEED = 32'hdb9e_1b31;

    // One trace line after parsing
    typedef struct packed {
        logic [7:0] cmd;
        addr_t      addr;
        data_t      wdata;
        strb_t      strb;
        data_t      exp_rdata;
        logic [1:0] exp_resp;
    } trace_entry_t;

    logic     aclk;
    logic     rst;
    logic     rtc;
    data_t    gpio_in;
    data_t    gpio_out;
    logic     timer_irq;
    logic     req_valid;
    logic     req_ready;
    bus_req_t req;
    logic     rsp_valid;
    logic     rsp_ready;
    bus_rsp_t rsp;
    logic     mem_req_valid;
    logic     mem_req_ready;
    bus_req_t mem_req;
    logic     mem_rsp_valid;
    logic     mem_rsp_ready;
    bus_rsp_t mem_rsp;

    trace_entry_t trace_q[$];
    int           entry_idx;
    int           errors;
    bit           trace_loaded;
    int           rsp_seed = SEED;
    int           mem_seed = SEED + 1;
    data_t        mem_words [logic [29:0]];

    platform_top i_dut (
        .aclk          (aclk),
        .rst           (rst),
        .rtc           (rtc),
        .gpio_in       (gpio_in),
        .gpio_out      (gpio_out),
        .timer_irq     (timer_irq),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req           (req),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .rsp           (rsp),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_ready (mem_rsp_ready),
        .mem_rsp       (mem_rsp)
    );

    always #5 aclk = ~aclk;

    //////////////////////////////
    // Memory model helpers
    //////////////////////////////

    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input strb_t strb);
        data_t result;
        result = old_word;
        for (int b = 0; b < $bits(strb_t); b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    // Unwritten words read back as the inverted word address
    function automatic data_t mem_read(input addr_t a);
        if (mem_words.exists(a[31:2])) begin
            return mem_words[a[31:2]];
        end
        return ~{a[31:2], 2'b00};
    endfunction

    //////////////////////////////
    // Checks and reporting
    //////////////////////////////

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h at trace entry %0d",
                     name, got, exp, entry_idx);
            errors++;
        end
    endtask

    task automatic print_summary();
        $display("Summary: %0d check errors, %0d assertion failures",
                 errors, i_dut.props.fail_count);
    endtask

    task automatic load_trace(output bit ok);
        int          fd;
        int          n;
        string       line;
        logic [7:0]  c;
        logic [31:0] a;
        logic [31:0] w;
        logic [31:0] s;
        logic [31:0] e;
        logic [31:0] r;
        trace_entry_t t;
        ok = 1'b0;
        fd = $fopen("dv/platform_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file dv/platform_trace.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%c %h %h %h %h %h", c, a, w, s, e, r);
                // Comment and blank lines fall out here
                if (n == 6 && c != "#") begin
                    t.cmd       = c;
                    t.addr      = a;
                    t.wdata     = w;
                    t.strb      = s[3:0];
                    t.exp_rdata = e;
                    t.exp_resp  = r[1:0];
                    trace_q.push_back(t);
                end
            end
            $fclose(fd);
            ok = (trace_q.size() > 0);
            if (!ok) begin
                $display("The trace file holds no entries");
                errors++;
            end
        end
    endtask

    //////////////////////////////
    // Requester side
    //////////////////////////////

    task automatic bus_transfer(input bus_req_t r, output bus_rsp_t got);
        bit taken;
        req       = r;
        req_valid = 1'b1;
        @(negedge aclk);
        while (!req_ready) begin
            @(negedge aclk);
        end
        @(posedge aclk);
        #1;
        req_valid = 1'b0;
        taken     = 1'b0;
        // Random back-pressure on the response channel
        while (!taken) begin
            rsp_ready = ($random(rsp_seed) & 3) != 0;
            @(negedge aclk);
            if (rsp_valid && rsp_ready) begin
                got   = rsp;
                taken = 1'b1;
            end
            @(posedge aclk);
            #1;
        end
        rsp_ready = 1'b0;
    endtask

    // Each level is long enough to pass the rtc synchronizer
    task automatic pulse_rtc(input data_t count);
        repeat (count) begin
            rtc = 1'b1;
            repeat (4) @(posedge aclk);
            #1;
            rtc = 1'b0;
            repeat (4) @(posedge aclk);
            #1;
        end
    endtask

    task automatic run_entry(input trace_entry_t t);
        bus_req_t r;
        bus_rsp_t got;
        case (t.cmd)
            "W", "R": begin
                r.op    = (t.cmd == "W") ? OP_WRITE : OP_READ;
                r.addr  = t.addr;
                r.wdata = t.wdata;
                r.strb  = t.strb;
                bus_transfer(r, got);
                if (t.cmd == "R") begin
                    check_value("rsp.rdata", got.rdata, t.exp_rdata);
                end
                check_value("rsp.resp", got.resp, t.exp_resp);
            end
            "T": pulse_rtc(t.wdata);
            "G": begin
                gpio_in = t.wdata;
                repeat (4) @(posedge aclk);
                #1;
            end
            "O": check_value("gpio_out", gpio_out, t.exp_rdata);
            // The last rtc edge has passed the synchronizer and the irq flop by now
            "I": check_value("timer_irq", timer_irq, t.exp_rdata[0]);
            default: begin
                $display("Unknown command in trace entry %0d", entry_idx);
                errors++;
            end
        endcase
    endtask

    //////////////////////////////
    // Processes
    //////////////////////////////

    initial begin : memory_model
        bus_req_t    mreq;
        int unsigned delay;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        @(posedge aclk);
        #1;
        forever begin
            mem_rsp_valid = 1'b0;
            mem_req_ready = ($random(mem_seed) & 1) != 0;
            @(negedge aclk);
            if (mem_req_valid && mem_req_ready) begin
                mreq = mem_req;
                @(posedge aclk);
                #1;
                mem_req_ready = 1'b0;
                delay         = $random(mem_seed) & 3;
                repeat (delay) begin
                    @(posedge aclk);
                    #1;
                end
                if (mreq.op == OP_WRITE) begin
                    mem_words[mreq.addr[31:2]] = merge_bytes(mem_read(mreq.addr),
                                                             mreq.wdata, mreq.strb);
                    mem_rsp = '{rdata: '0, resp: RESP_OKAY};
                end else begin
                    mem_rsp = '{rdata: mem_read(mreq.addr), resp: RESP_OKAY};
                end
                mem_rsp_valid = 1'b1;
                @(negedge aclk);
                while (!mem_rsp_ready) begin
                    @(negedge aclk);
                end
            end
            @(posedge aclk);
            #1;
        end
    end

    initial begin : watchdog
        wait (trace_loaded);
        repeat (trace_q.size() * 100) @(posedge aclk);
        $display("Watchdog expired after %0d cycles with trace entry %0d unfinished",
                 trace_q.size() * 100, entry_idx);
        errors++;
        print_summary();
        $display("Done: errors found");
        $finish;
    end

    initial begin : main
        bit ok;
        aclk         = 1'b0;
        rst          = 1'b1;
        rtc          = 1'b0;
        gpio_in      = '0;
        req_valid    = 1'b0;
        req          = '0;
        rsp_ready    = 1'b0;
        errors       = 0;
        entry_idx    = 0;
        trace_loaded = 1'b0;
        load_trace(ok);
        if (!ok) begin
            print_summary();
            $display("Done: errors found");
            $finish;
        end else begin
            trace_loaded = 1'b1;
            repeat (3) @(posedge aclk);
            #1;
            rst = 1'b0;
            for (entry_idx = 0; entry_idx < trace_q.size(); entry_idx++) begin
                run_entry(trace_q[entry_idx]);
            end
            print_summary();
            if (errors == 0 && i_dut.props.fail_count == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- dv/platform_trace.txt
# cmd addr wdata strb exp_rdata exp_resp, all hex; W/R check resp, R also checks rdata
# T pulses rtc (count in wdata), G drives gpio_in, O checks gpio_out, I checks timer_irq
W 00000100 12345678 f 00000000 0
R 00000100 00000000 0 12345678 0
W 00000100 aabbccdd 5 00000000 0
R 00000100 00000000 0 12bb56dd 0
W 00000104 0badf00d f 00000000 0
W 000ffffc deadbeef f 00000000 0
R 00000104 00000000 0 0badf00d 0
R 000ffffc 00000000 0 deadbeef 0
W 000ffffc 11223344 a 00000000 0
R 000ffffc 00000000 0 11ad33ef 0
R 00000200 00000000 0 fffffdff 0
W 00100000 cafef00d f 00000000 0
O 00000000 00000000 0 cafef00d 0
W 00100000 00005500 2 00000000 0
O 00000000 00000000 0 cafe550d 0
R 00100000 00000000 0 cafe550d 0
G 00000000 a5a5c3c3 0 00000000 0
R 00100004 00000000 0 a5a5c3c3 0
W 00100004 ffffffff f 00000000 0
O 00000000 00000000 0 cafe550d 0
R 00100008 00000000 0 00000000 2
R 00100020 00000000 0 00000000 3
W 80000000 12345678 f 00000000 3
R 00200000 00000000 0 00000000 3
W 00100010 00001000 f 00000000 0
W 00100014 00000000 f 00000000 0
R 00100010 00000000 0 00001000 0
T 00000000 00000003 0 00000000 0
R 00100010 00000000 0 00001003 0
R 00100014 00000000 0 00000000 0
W 00100018 00001005 f 00000000 0
W 0010001c 00000000 f 00000000 0
I 00000000 00000000 0 00000000 0
T 00000000 00000001 0 00000000 0
I 00000000 00000000 0 00000000 0
T 00000000 00000001 0 00000000 0
I 00000000 00000000 0 00000001 0
W 0010001c ffffffff f 00000000 0
W 00100018 ffffffff f 00000000 0
I 00000000 00000000 0 00000000 0
R 00100018 00000000 0 ffffffff 0

//--- tb.f
+incdir+logic
logic/bus_pkg.sv
logic/io_pkg.sv
logic/request_slice.sv
logic/address_decoder.sv
logic/gpio_bank.sv
logic/machine_timer.sv
logic/platform_top.sv
dv/platform_properties.sv
dv/platform_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = platform_tb
FILELIST  = tb.f
SIMFLAGS  = +verilator+error+limit+1000
LOG       = sim.log
PASS_MSG  = Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir obj_dir
	-./obj_dir/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
